/* build.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/cpu_control.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/bus_wb8.sv
rtl/cpu_top.sv
test/tb_memory.sv
test/tb_cpu.sv

/* test/tb_cpu.sv */
module tb_cpu import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam word_t LOOP_PC    = 32'd140;
    localparam word_t JAL_PC     = 32'd128;
    localparam word_t DATA_BASE  = 32'h100;
    localparam int    N_STORES   = 10;
    localparam int    MAX_CYCLES = 6000;

    logic  clk;
    logic  reset;
    word_t bus_addr;
    byte_t bus_wdata;
    byte_t bus_rdata;
    logic  bus_cyc;
    logic  bus_stb;
    logic  bus_we;
    logic  bus_ack;
    int    proto_errors;
    int    errors;

    word_t exp_data [N_STORES];
    int    store_count;
    int    xfer_count;
    int    loop_hits;       // fetches of the self loop
    int    st_byte;
    word_t st_addr;
    word_t st_word;         // store rebuilt from bytes
    logic  reset_q;
    logic  reset_qq;
    int    cycles;

    cpu_top DUT (.*);

    tb_memory u_mem (.*, .errors(proto_errors));

    always #20 clk = ~clk;

    task automatic report_mismatch(string name, word_t expected, word_t actual);
        errors++;
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    // register values the program should produce
    task automatic build_expected();
        word_t x1, x2, x3, x4, x5, x6, x7, x8, x10;
        x1  = {20'h12345, 12'h000};
        x2  = 32'd100;
        x3  = word_t'(-7);
        x4  = x1 + x2;
        x5  = x2 - x3;
        x6  = x4 ^ x3;
        x7  = (x6 & x1) | x5;
        x10 = ~((x6 & 32'h7f0) | 32'h00f);
        // each compare is true only with the right signedness
        x8  = int'($signed(x3) < $signed(x2)) + int'(x2 < x3)
            + int'($signed(x3) < 5) + int'(x2 < 32'hffff_ffff);
        exp_data = '{x1, x4, x5, x6, x7, x10, x8, x4, x2, JAL_PC + 32'd4};
    endtask

    task automatic check_store();
        if (store_count < N_STORES) begin
            assert (st_addr == DATA_BASE + 4 * store_count)
                else report_mismatch("store address", DATA_BASE + 4 * store_count, st_addr);
            assert (st_word == exp_data[store_count])
                else report_mismatch("store word", exp_data[store_count], st_word);
        end else begin
            errors++;
            $display("time %0t: extra store of %h to %h", $time, st_word, st_addr);
        end
        store_count++;
    endtask

    always @(posedge clk) begin
        if (reset_q || reset_qq)
            assert (bus_cyc === 1'b0 && bus_stb === 1'b0 && bus_we === 1'b0) else begin
                errors++;
                $display("time %0t: bus is not idle during or right after reset", $time);
            end
        reset_qq = reset_q;
        reset_q  = reset;
        if (!reset && bus_stb && bus_ack) begin
            if (xfer_count < 4) begin   // first fetch from the reset vector
                assert (!bus_we) else begin
                    errors++;
                    $display("time %0t: first transfers are not reads", $time);
                end
                assert (bus_addr == word_t'(xfer_count))
                    else report_mismatch("bus_addr", word_t'(xfer_count), bus_addr);
            end
            xfer_count++;
            if (bus_we) begin
                if (st_byte == 0)
                    st_addr = bus_addr;
                st_word[8*st_byte +: 8] = bus_wdata;
                st_byte++;
                if (st_byte == 4) begin
                    check_store();
                    st_byte = 0;
                end
            end else if (bus_addr == LOOP_PC)
                loop_hits++;
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        errors      = 0;
        store_count = 0;
        xfer_count  = 0;
        loop_hits   = 0;
        st_byte     = 0;
        st_word     = '0;
        reset_q     = 1'b0;
        reset_qq    = 1'b0;
        build_expected();
        repeat (10) @(posedge clk);
        #2 reset = 1'b0;

        cycles = 0;
        while (loop_hits < 2 && cycles < MAX_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (loop_hits < 2) begin
            errors++;
            $display("timeout: self loop at %h not reached in %0d cycles", LOOP_PC, MAX_CYCLES);
        end
        assert (store_count == N_STORES) else begin
            errors++;
            $display("saw %0d stores where %0d were expected", store_count, N_STORES);
        end

        $display("errors: %0d data, %0d protocol", errors, proto_errors);
        if (errors == 0 && proto_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* test/tb_memory.sv */
module tb_memory import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  word_t bus_addr,
    input  byte_t bus_wdata,
    input  logic  bus_cyc,
    input  logic  bus_stb,
    input  logic  bus_we,
    output byte_t bus_rdata,
    output logic  bus_ack,
    output int    errors
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_BYTES = 512;

    byte_t      mem [MEM_BYTES];
    int         load_ptr;
    logic [7:0] lfsr;
    int         wait_left;      // cycles before ack for the current byte
    logic       in_byte;
    logic       held;           // strobe seen without ack at the last edge
    word_t      held_addr;
    byte_t      held_wdata;
    logic       held_we;
    word_t      last_addr;
    int         byte_idx;
    logic       rst_s;

    function automatic word_t r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic word_t i_type(opcode_t opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    // sw src, off(base)
    function automatic word_t s_type(int base, int src, int off);
        return {off[11:5], src[4:0], base[4:0], 3'b010, off[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_type(int imm20, int rd);
        return {imm20[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic word_t j_type(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic logic [7:0] lfsr_next(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};    // x^8 + x^6 + x^5 + x^4 + 1
    endfunction

    task automatic put_word(word_t w);
        for (int b = 0; b < 4; b++)
            mem[load_ptr + b] = w[8*b +: 8];   // little endian
        load_ptr += 4;
    endtask

    task automatic report_mismatch(string name, word_t expected, word_t actual);
        errors++;
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    initial begin
        errors    = 0;
        bus_ack   = 1'b0;
        bus_rdata = '0;
        lfsr      = 8'd91;
        wait_left = 0;
        in_byte   = 1'b0;
        held      = 1'b0;
        byte_idx  = 0;
        load_ptr  = 0;
        for (int i = 0; i < MEM_BYTES; i++)
            mem[i] = byte_t'(i ^ (i >> 8) ^ 8'h5a);
        put_word(u_type(32'h12345, 1));                      // 0   lui x1
        put_word(i_type(OPC_OPIMM, F3_ADD_SUB, 2, 0, 100));  // 4   addi x2
        put_word(i_type(OPC_OPIMM, F3_ADD_SUB, 3, 0, -7));   // 8   addi x3
        put_word(i_type(OPC_OPIMM, F3_ADD_SUB, 15, 0, 256)); // 12  data base in x15
        put_word(s_type(15, 1, 0));                          // 16
        put_word(r_type(0, F3_ADD_SUB, 4, 1, 2));            // 20  add
        put_word(s_type(15, 4, 4));                          // 24
        put_word(r_type(32, F3_ADD_SUB, 5, 2, 3));           // 28  sub
        put_word(s_type(15, 5, 8));                          // 32
        put_word(r_type(0, F3_XOR, 6, 4, 3));                // 36
        put_word(s_type(15, 6, 12));                         // 40
        put_word(r_type(0, F3_AND, 7, 6, 1));                // 44
        put_word(r_type(0, F3_OR, 7, 7, 5));                 // 48
        put_word(s_type(15, 7, 16));                         // 52
        put_word(i_type(OPC_OPIMM, F3_AND, 10, 6, 'h7f0));   // 56  andi
        put_word(i_type(OPC_OPIMM, F3_OR, 10, 10, 'h00f));   // 60  ori
        put_word(i_type(OPC_OPIMM, F3_XOR, 10, 10, -1));     // 64  xori
        put_word(s_type(15, 10, 20));                        // 68
        put_word(r_type(0, F3_SLT, 8, 3, 2));                // 72
        put_word(r_type(0, F3_SLTU, 9, 2, 3));               // 76
        put_word(i_type(OPC_OPIMM, F3_SLT, 11, 3, 5));       // 80  slti
        put_word(i_type(OPC_OPIMM, F3_SLTU, 12, 2, -1));     // 84  sltiu
        put_word(r_type(0, F3_ADD_SUB, 8, 8, 9));            // 88
        put_word(r_type(0, F3_ADD_SUB, 8, 8, 11));           // 92
        put_word(r_type(0, F3_ADD_SUB, 8, 8, 12));           // 96
        put_word(s_type(15, 8, 24));                         // 100
        put_word(i_type(OPC_LOAD, 3'b010, 13, 15, 4));       // 104 lw x13, 4(x15)
        put_word(s_type(15, 13, 28));                        // 108
        put_word(b_type(F3_BEQ, 2, 2, 8));                   // 112 taken
        put_word(s_type(15, 0, 32));                         // 116 skipped marker
        put_word(b_type(F3_BNE, 2, 2, 8));                   // 120 not taken
        put_word(s_type(15, 2, 32));                         // 124 marker
        put_word(j_type(14, 8));                             // 128 jal x14
        put_word(s_type(15, 0, 36));                         // 132 skipped marker
        put_word(s_type(15, 14, 36));                        // 136
        put_word(j_type(0, 0));                              // 140 self loop
    end

    always @(posedge clk) begin
        rst_s = reset;
        if (rst_s) begin
            in_byte  = 1'b0;
            held     = 1'b0;
            byte_idx = 0;
        end else begin
            assert (!bus_stb || bus_cyc) else begin
                errors++;
                $display("time %0t: bus_stb is high while bus_cyc is low", $time);
            end
            // request must stay frozen while ack is low
            if (held) begin
                assert (bus_stb) else begin
                    errors++;
                    $display("time %0t: bus_stb dropped before ack", $time);
                end
                assert (bus_addr == held_addr)
                    else report_mismatch("bus_addr", held_addr, bus_addr);
                assert (bus_wdata === held_wdata)
                    else report_mismatch("bus_wdata", word_t'(held_wdata), word_t'(bus_wdata));
                assert (bus_we == held_we)
                    else report_mismatch("bus_we", word_t'(held_we), word_t'(bus_we));
            end
            if (bus_stb && bus_ack) begin
                if (byte_idx != 0)
                    assert (bus_addr == last_addr + 1)
                        else report_mismatch("bus_addr", last_addr + 1, bus_addr);
                assert (bus_addr < MEM_BYTES) else begin
                    errors++;
                    $display("time %0t: access to %h is outside the memory", $time, bus_addr);
                end
                if (bus_we)
                    mem[bus_addr[8:0]] = bus_wdata;
                last_addr = bus_addr;
                byte_idx  = (byte_idx + 1) % 4;
                in_byte   = 1'b0;
            end
            held       = bus_stb && !bus_ack;
            held_addr  = bus_addr;
            held_wdata = bus_wdata;
            held_we    = bus_we;
        end
        #2;
        bus_ack = 1'b0;
        if (!rst_s && bus_cyc && bus_stb) begin
            if (!in_byte) begin     // draw 0 to 3 wait cycles for a new byte
                in_byte   = 1'b1;
                lfsr      = lfsr_next(lfsr);
                wait_left = int'(lfsr[0]);
                lfsr      = lfsr_next(lfsr);
                wait_left = wait_left + 2 * int'(lfsr[0]);
            end
            if (wait_left == 0) begin
                bus_ack   = 1'b1;
                bus_rdata = mem[bus_addr[8:0]];
            end else
                wait_left--;
        end
    end

endmodule

/* rtl/cpu_top.sv */
module cpu_top import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    output word_t bus_addr,
    output byte_t bus_wdata,
    output logic  bus_cyc,
    output logic  bus_stb,
    output logic  bus_we,
    input  byte_t bus_rdata,
    input  logic  bus_ack
);

    word_t      pc, alu_result, imm, bus_word, rs1_val, rs2_val;
    logic       bus_start, bus_write, addr_from_alu, bus_done;
    logic       instr_load, reg_we, alu_eq, funct7_5;
    opcode_t    opcode;
    funct3_t    funct3;
    reg_addr_t  rs1, rs2, rd;
    wb_sel_e    wb_sel;
    alu_op_e    alu_op;
    alu_a_sel_e alu_a_sel;
    alu_b_sel_e alu_b_sel;

    cpu_control u_control (.*);

    instr_decoder u_decoder (.*);

    register_file u_regs (.*);

    alu u_alu (.*);

    // byte engine towards the 8-bit bus
    bus_wb8 u_bus (.*);

endmodule

/* rtl/bus_wb8.sv */
module bus_wb8 import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  bus_start,
    input  logic  bus_write,
    input  logic  addr_from_alu,
    input  word_t pc,
    input  word_t alu_result,
    input  word_t rs2_val,
    input  byte_t bus_rdata,
    input  logic  bus_ack,
    output word_t bus_addr,
    output byte_t bus_wdata,
    output logic  bus_cyc,
    output logic  bus_stb,
    output logic  bus_we,
    output word_t bus_word,
    output logic  bus_done
);

    logic [1:0] byte_cnt;
    word_t      wdata_q;    // store word, shifted out lsb first
    logic       launch;
    logic       xfer;

    assign launch    = bus_start && !bus_cyc;
    assign xfer      = bus_stb && bus_ack;   // one byte completes
    assign bus_wdata = wdata_q[7:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_cyc  <= 1'b0;
            bus_stb  <= 1'b0;
            bus_we   <= 1'b0;
            bus_done <= 1'b0;
            byte_cnt <= 2'd0;
        end else begin
            bus_done <= 1'b0;
            if (launch) begin
                bus_cyc  <= 1'b1;
                bus_stb  <= 1'b1;
                bus_we   <= bus_write;
                byte_cnt <= 2'd0;
            end else if (xfer) begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'd3) begin     // last byte of the word
                    bus_cyc  <= 1'b0;
                    bus_stb  <= 1'b0;
                    bus_we   <= 1'b0;
                    bus_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            bus_addr <= addr_from_alu ? alu_result : pc;
            wdata_q  <= rs2_val;
        end else if (xfer) begin
            bus_addr <= bus_addr + 32'd1;
            wdata_q  <= {8'h00, wdata_q[31:8]};
            if (!bus_we)
                bus_word <= {bus_rdata, bus_word[31:8]};    // little endian fill
        end
    end

endmodule

/* rtl/alu.sv */
`include "cpu_macros.svh"

module alu import cpu_pkg::*; (
    input  alu_op_e    alu_op,
    input  alu_a_sel_e alu_a_sel,
    input  alu_b_sel_e alu_b_sel,
    input  word_t      rs1_val,
    input  word_t      rs2_val,
    input  word_t      pc,
    input  word_t      imm,
    output word_t      alu_result,
    output logic       alu_eq
);

    word_t op_a, op_b;

    assign op_a = (alu_a_sel == A_PC) ? pc : rs1_val;

    always_comb begin
        case (alu_b_sel)
            B_IMM:   op_b = imm;
            B_ILEN:  op_b = word_t'(`CPU_INSTR_LEN);   // next instruction
            default: op_b = rs2_val;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SLT:  alu_result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_result = word_t'(op_a < op_b);
            default:  alu_result = op_a + op_b;
        endcase
    end

    assign alu_eq = (op_a == op_b);    // beq/bne

endmodule

/* rtl/register_file.sv */
`include "cpu_macros.svh"

module register_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reg_we,
    input  wb_sel_e   wb_sel,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  word_t     alu_result,
    input  word_t     bus_word,
    input  word_t     imm,
    output word_t     rs1_val,
    output word_t     rs2_val
);

    word_t regs [`CPU_NREGS];
    word_t wr_data;

    always_comb begin
        case (wb_sel)
            WB_BUS:  wr_data = bus_word;
            WB_IMM:  wr_data = imm;     // lui
            default: wr_data = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reg_we && rd != '0)
            regs[rd] <= wr_data;
    end

    // x0 reads as zero
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* rtl/instr_decoder.sv */
module instr_decoder import cpu_pkg::*; (
    input  logic      clk,
    input  logic      instr_load,
    input  word_t     bus_word,
    output opcode_t   opcode,
    output funct3_t   funct3,
    output logic      funct7_5,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output word_t     imm
);

    word_t ir;

    always_ff @(posedge clk) begin
        if (instr_load)
            ir <= bus_word;
    end

    assign opcode   = ir[6:0];
    assign rd       = ir[11:7];
    assign funct3   = ir[14:12];
    assign rs1      = ir[19:15];
    assign rs2      = ir[24:20];
    assign funct7_5 = ir[30];   // sub select

    // immediate format follows the opcode
    always_comb begin
        case (opcode)
            OPC_STORE:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            OPC_BRANCH: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            OPC_LUI:    imm = {ir[31:12], 12'h000};
            OPC_JAL:    imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:    imm = {{20{ir[31]}}, ir[31:20]};    // I format
        endcase
    end

endmodule

/* rtl/cpu_control.sv */
`include "cpu_macros.svh"

module cpu_control import cpu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       bus_done,
    input  opcode_t    opcode,
    input  funct3_t    funct3,
    input  logic       funct7_5,
    input  word_t      alu_result,
    input  logic       alu_eq,
    output word_t      pc,
    output logic       bus_start,
    output logic       bus_write,
    output logic       addr_from_alu,
    output logic       instr_load,
    output logic       reg_we,
    output wb_sel_e    wb_sel,
    output alu_op_e    alu_op,
    output alu_a_sel_e alu_a_sel,
    output alu_b_sel_e alu_b_sel
);

    cpu_state_e state;
    word_t      pc_next;        // pc + 4, taken in decode
    logic       bus_active;     // start issued, done not yet seen
    alu_op_e    funct_op;
    logic       is_shift;
    logic       branch_taken;

    // operation picked from funct3, sub only for register-register
    always_comb begin
        case (funct3)
            F3_ADD_SUB: funct_op = (opcode == OPC_OP && funct7_5) ? ALU_SUB : ALU_ADD;
            F3_SLT:     funct_op = ALU_SLT;
            F3_SLTU:    funct_op = ALU_SLTU;
            F3_XOR:     funct_op = ALU_XOR;
            F3_OR:      funct_op = ALU_OR;
            F3_AND:     funct_op = ALU_AND;
            default:    funct_op = ALU_ADD;
        endcase
    end

    assign is_shift = (funct3[1:0] == 2'b01);  // sll/srl/sra, not kept
    assign branch_taken = (funct3 == F3_BEQ && alu_eq) || (funct3 == F3_BNE && !alu_eq);

    // per-state datapath controls
    always_comb begin
        bus_start     = 1'b0;
        bus_write     = 1'b0;
        addr_from_alu = 1'b0;
        instr_load    = 1'b0;
        reg_we        = 1'b0;
        wb_sel        = WB_ALU;
        alu_op        = ALU_ADD;
        alu_a_sel     = A_RS1;
        alu_b_sel     = B_RS2;
        case (state)
            S_FETCH: bus_start = !bus_active;
            S_DECODE: begin
                instr_load = 1'b1;
                alu_a_sel  = A_PC;      // pc + 4 while the ALU is idle
                alu_b_sel  = B_ILEN;
            end
            S_EXEC: begin
                if (opcode == OPC_JAL) begin
                    reg_we    = 1'b1;   // link register gets pc + 4
                    alu_a_sel = A_PC;
                    alu_b_sel = B_ILEN;
                end
            end
            S_LOAD, S_STORE: begin
                alu_b_sel     = B_IMM;  // rs1 + offset
                addr_from_alu = 1'b1;
                bus_write     = (state == S_STORE);
                bus_start     = !bus_active;
            end
            S_JUMP: begin
                alu_a_sel = A_PC;
                alu_b_sel = B_IMM;
            end
            S_WRITEBACK: begin
                reg_we    = 1'b1;
                alu_op    = funct_op;
                alu_b_sel = (opcode == OPC_OPIMM) ? B_IMM : B_RS2;
                if (opcode == OPC_LOAD)
                    wb_sel = WB_BUS;
                else if (opcode == OPC_LUI)
                    wb_sel = WB_IMM;
            end
            default: ;  // branch compares rs1 with rs2 on the defaults
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_RESET;
            pc         <= `CPU_RESET_VECTOR;
            bus_active <= 1'b0;
        end else begin
            if (bus_done)
                bus_active <= 1'b0;
            else if (bus_start)
                bus_active <= 1'b1;

            case (state)
                S_RESET: state <= S_FETCH;
                S_FETCH: if (bus_done) state <= S_DECODE;
                S_DECODE: begin
                    pc_next <= alu_result;
                    state   <= S_EXEC;
                end
                S_EXEC: begin
                    case (opcode)
                        OPC_OP, OPC_OPIMM: state <= is_shift ? S_NEXT : S_WRITEBACK;
                        OPC_LUI:           state <= S_WRITEBACK;
                        OPC_LOAD:          state <= S_LOAD;
                        OPC_STORE:         state <= S_STORE;
                        OPC_BRANCH:        state <= S_BRANCH;
                        OPC_JAL:           state <= S_JUMP;
                        default:           state <= S_NEXT;     // treated as nop
                    endcase
                end
                S_LOAD:  if (bus_done) state <= S_WRITEBACK;
                S_STORE: if (bus_done) state <= S_NEXT;
                S_BRANCH: state <= branch_taken ? S_JUMP : S_NEXT;
                S_JUMP: begin
                    pc    <= alu_result;    // pc + imm
                    state <= S_FETCH;
                end
                S_WRITEBACK: state <= S_NEXT;
                S_NEXT: begin
                    pc    <= pc_next;
                    state <= S_FETCH;
                end
                default: state <= S_RESET;
            endcase
        end
    end

endmodule

/* rtl/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;   // data word or address
    typedef logic [7:0] byte_t;             // one bus lane
    typedef logic [4:0] reg_addr_t;

    typedef logic [6:0] opcode_t;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    typedef logic [2:0] funct3_t;
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU} alu_op_e;

    typedef enum logic {A_RS1, A_PC} alu_a_sel_e;
    typedef enum logic [1:0] {B_RS2, B_IMM, B_ILEN} alu_b_sel_e;

    typedef enum logic [1:0] {WB_ALU, WB_BUS, WB_IMM} wb_sel_e;

    typedef enum logic [3:0] {
        S_RESET,
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_LOAD,
        S_STORE,
        S_BRANCH,
        S_JUMP,
        S_WRITEBACK,
        S_NEXT
    } cpu_state_e;

endpackage

/* rtl/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width
`define CPU_XLEN 32

// general registers, x0 included
`define CPU_NREGS 32

// address of the first fetch
`define CPU_RESET_VECTOR 32'h0000_0000

// pc step in bytes
`define CPU_INSTR_LEN 4

`endif
